// ==== hw/flash_ctrl_pkg.sv ====
package flash_ctrl_pkg;

    typedef logic [23:0] flash_addr_t;
    typedef logic [31:0] flash_word_t;
    typedef logic [7:0]  flash_opcode_t;
    typedef logic [63:0] frame_bits_t;   // left aligned, sent msb first
    typedef logic [6:0]  bit_count_t;    // 0..64

    // serial nor command set, single bit spi
    localparam flash_opcode_t OP_READ_ID      = 8'h90;
    localparam flash_opcode_t OP_WREN         = 8'h06;
    localparam flash_opcode_t OP_READ         = 8'h03;
    localparam flash_opcode_t OP_PROGRAM      = 8'h02;
    localparam flash_opcode_t OP_SECTOR_ERASE = 8'h20;
    localparam flash_opcode_t OP_READ_STATUS  = 8'h05;

    localparam int STATUS_WIP_BIT = 0;   // write in progress

    // frame lengths in bits
    localparam bit_count_t LEN_OPCODE  = 7'd8;
    localparam bit_count_t LEN_CMD     = 7'd32;   // opcode + address
    localparam bit_count_t LEN_CMD_DAT = 7'd64;   // opcode + address + word
    localparam bit_count_t LEN_ID      = 7'd16;
    localparam bit_count_t LEN_WORD    = 7'd32;
    localparam bit_count_t LEN_STATUS  = 7'd8;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WREN,
        ST_COMMAND,
        ST_POLL,
        ST_DONE
    } op_state_t;

    typedef enum logic [1:0] {
        PWR_ID,
        PWR_WREN,
        PWR_FINISHED
    } pwr_state_t;

endpackage

// ==== hw/power_up_sequencer.sv ====
`timescale 1ns/1ps

module power_up_sequencer
    import flash_ctrl_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    output logic        req,
    output frame_bits_t tx_bits,
    output bit_count_t  tx_len,
    output bit_count_t  rx_len,
    input  logic        done,
    output logic        active
);

    pwr_state_t state;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state  <= PWR_ID;
            req    <= 1'b0;
            active <= 1'b0;
        end else begin
            case (state)
                PWR_ID: begin
                    active <= 1'b1;
                    if (done) begin
                        req   <= 1'b0;   // id bits are dropped
                        state <= PWR_WREN;
                    end else begin
                        req <= 1'b1;
                    end
                end
                PWR_WREN: begin
                    if (done) begin
                        req    <= 1'b0;
                        active <= 1'b0;
                        state  <= PWR_FINISHED;
                    end else begin
                        req <= 1'b1;
                    end
                end
                default: req <= 1'b0;
            endcase
        end
    end

    always_comb begin
        tx_bits = {OP_WREN, 56'd0};
        tx_len  = LEN_OPCODE;
        rx_len  = '0;
        if (state == PWR_ID) begin
            tx_bits = {OP_READ_ID, 24'd0, 32'd0};   // opcode + zero address
            tx_len  = LEN_CMD;
            rx_len  = LEN_ID;
        end
    end

endmodule

// ==== hw/flash_op_sequencer.sv ====
`timescale 1ns/1ps

module flash_op_sequencer
    import flash_ctrl_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        start,
    input  flash_addr_t addr,
    input  flash_word_t wdata,
    input  logic        write,
    input  logic        erase,
    input  logic        hold,
    output logic        req,
    output frame_bits_t tx_bits,
    output bit_count_t  tx_len,
    output bit_count_t  rx_len,
    input  logic        done,
    input  flash_word_t rx_data,
    output flash_word_t rdata,
    output logic        valid,
    output logic        busy
);

    op_state_t     state;
    flash_addr_t   cmd_addr;
    flash_word_t   cmd_data;
    flash_opcode_t cmd_op;
    logic          accept;
    logic          is_read;

    assign accept  = (state == ST_IDLE) & start & ~hold;
    assign is_read = (cmd_op == OP_READ);

    assign busy  = (state != ST_IDLE);
    assign valid = (state == ST_DONE);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= ST_IDLE;
            req   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= (write || erase) ? ST_WREN : ST_COMMAND;
                    end
                end
                ST_WREN: begin
                    if (done) begin
                        req   <= 1'b0;
                        state <= ST_COMMAND;
                    end else begin
                        req <= 1'b1;
                    end
                end
                ST_COMMAND: begin
                    if (done) begin
                        req   <= 1'b0;
                        state <= is_read ? ST_DONE : ST_POLL;
                    end else begin
                        req <= 1'b1;
                    end
                end
                ST_POLL: begin
                    // still busy: req drops for a cycle, then a fresh status frame
                    if (done) begin
                        req <= 1'b0;
                        if (!rx_data[STATUS_WIP_BIT]) begin
                            state <= ST_DONE;
                        end
                    end else begin
                        req <= 1'b1;
                    end
                end
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            cmd_addr <= addr;
            cmd_data <= wdata;
            if (erase) begin
                cmd_op <= OP_SECTOR_ERASE;
            end else if (write) begin
                cmd_op <= OP_PROGRAM;
            end else begin
                cmd_op <= OP_READ;
            end
        end
        if (state == ST_COMMAND && done && is_read) begin
            rdata <= rx_data;
        end
    end

    always_comb begin
        tx_bits = '0;
        tx_len  = '0;
        rx_len  = '0;
        case (state)
            ST_WREN: begin
                tx_bits = {OP_WREN, 56'd0};
                tx_len  = LEN_OPCODE;
            end
            ST_COMMAND: begin
                tx_bits = {cmd_op, cmd_addr, cmd_data};   // data goes out for program only
                tx_len  = (cmd_op == OP_PROGRAM) ? LEN_CMD_DAT : LEN_CMD;
                rx_len  = is_read ? LEN_WORD : 7'd0;
            end
            ST_POLL: begin
                tx_bits = {OP_READ_STATUS, 56'd0};
                tx_len  = LEN_OPCODE;
                rx_len  = LEN_STATUS;
            end
            default: begin
                tx_bits = '0;
            end
        endcase
    end

endmodule

// ==== hw/frame_arbiter.sv ====
`timescale 1ns/1ps

module frame_arbiter
    import flash_ctrl_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        pwr_req,
    input  frame_bits_t pwr_tx_bits,
    input  bit_count_t  pwr_tx_len,
    input  bit_count_t  pwr_rx_len,
    output logic        pwr_done,
    input  logic        op_req,
    input  frame_bits_t op_tx_bits,
    input  bit_count_t  op_tx_len,
    input  bit_count_t  op_rx_len,
    output logic        op_done,
    output logic        eng_req,
    output frame_bits_t eng_tx_bits,
    output bit_count_t  eng_tx_len,
    output bit_count_t  eng_rx_len,
    input  logic        eng_done
);

    logic locked;
    logic owner_op;   // 1 = operation sequencer holds the engine
    logic sel_op;

    // power-up wins when both ask in the same cycle
    assign sel_op = locked ? owner_op : ~pwr_req;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            locked   <= 1'b0;
            owner_op <= 1'b0;
        end else if (eng_done) begin
            locked <= 1'b0;
        end else if (!locked && eng_req) begin
            locked   <= 1'b1;
            owner_op <= sel_op;
        end
    end

    assign eng_req     = sel_op ? op_req     : pwr_req;
    assign eng_tx_bits = sel_op ? op_tx_bits : pwr_tx_bits;
    assign eng_tx_len  = sel_op ? op_tx_len  : pwr_tx_len;
    assign eng_rx_len  = sel_op ? op_rx_len  : pwr_rx_len;

    assign pwr_done = eng_done & locked & ~owner_op;
    assign op_done  = eng_done & locked & owner_op;

endmodule

// ==== hw/spi_frame_engine.sv ====
`timescale 1ns/1ps

module spi_frame_engine
    import flash_ctrl_pkg::*;
#(
    parameter int CLK_DIV = 2
) (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        req,
    input  frame_bits_t tx_bits,
    input  bit_count_t  tx_len,
    input  bit_count_t  rx_len,
    output logic        done,
    output flash_word_t rx_data,
    output logic        flash_cs,
    output logic        flash_sck,
    output logic        flash_mosi,
    input  logic        flash_miso
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_SETUP,   // cs setup before first edge
        ENG_SHIFT,
        ENG_HOLD,    // sck low, cs still asserted
        ENG_GAP      // cs high between frames
    } eng_state_t;

    eng_state_t       state;
    logic [DIV_W-1:0] div_cnt;
    logic             half_tick;
    logic             sck_int;
    bit_count_t       bit_cnt;     // rising edges so far
    bit_count_t       frame_len;
    frame_bits_t      tx_shift;
    logic             sample;

    assign half_tick = (div_cnt == DIV_W'(CLK_DIV - 1));
    assign frame_len = bit_count_t'(tx_len + rx_len);

    // flash_sck still low here, it rises on this clock edge
    assign sample = sck_int & ~flash_sck & (bit_cnt > tx_len);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            div_cnt <= '0;
        end else if (state == ENG_IDLE || half_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state     <= ENG_IDLE;
            flash_cs  <= 1'b1;
            sck_int   <= 1'b0;
            flash_sck <= 1'b0;
            bit_cnt   <= '0;
            done      <= 1'b0;
        end else begin
            flash_sck <= sck_int;   // one clock behind, matches mosi delay
            done      <= 1'b0;
            case (state)
                ENG_IDLE: begin
                    if (req) begin
                        bit_cnt <= '0;
                        state   <= ENG_SETUP;
                    end
                end
                ENG_SETUP: begin
                    if (half_tick) begin
                        flash_cs <= 1'b0;
                        state    <= ENG_SHIFT;
                    end
                end
                ENG_SHIFT: begin
                    if (half_tick) begin
                        sck_int <= ~sck_int;
                        if (!sck_int) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end else if (bit_cnt == frame_len) begin
                            state <= ENG_HOLD;   // last falling edge
                        end
                    end
                end
                ENG_HOLD: begin
                    if (half_tick) begin
                        flash_cs <= 1'b1;
                        done     <= 1'b1;
                        state    <= ENG_GAP;
                    end
                end
                ENG_GAP: begin
                    if (half_tick) begin
                        state <= ENG_IDLE;
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        flash_mosi <= tx_shift[$bits(frame_bits_t)-1];
        if (state == ENG_IDLE && req) begin
            tx_shift <= tx_bits;
            rx_data  <= '0;
        end else begin
            if (state == ENG_SHIFT && half_tick && sck_int) begin
                tx_shift <= tx_shift << 1;   // next bit on falling sck
            end
            if (sample) begin
                rx_data <= {rx_data[$bits(flash_word_t)-2:0], flash_miso};
            end
        end
    end

endmodule

// ==== hw/flash_ctrl_top.sv ====
`timescale 1ns/1ps

module flash_ctrl_top
    import flash_ctrl_pkg::*;
#(
    parameter int CLK_DIV = 2   // clocks per sck half period
) (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        start,
    input  flash_addr_t addr,
    input  flash_word_t wdata,
    input  logic        write,
    input  logic        erase,
    output flash_word_t rdata,
    output logic        valid,
    output logic        busy,
    output logic        flash_cs,
    output logic        flash_sck,
    output logic        flash_mosi,
    input  logic        flash_miso
);

    logic        pwr_req;
    frame_bits_t pwr_tx_bits;
    bit_count_t  pwr_tx_len;
    bit_count_t  pwr_rx_len;
    logic        pwr_done;
    logic        pwr_active;

    logic        op_req;
    frame_bits_t op_tx_bits;
    bit_count_t  op_tx_len;
    bit_count_t  op_rx_len;
    logic        op_done;
    logic        op_busy;

    logic        eng_req;
    frame_bits_t eng_tx_bits;
    bit_count_t  eng_tx_len;
    bit_count_t  eng_rx_len;
    logic        eng_done;
    flash_word_t eng_rx_data;

    assign busy = pwr_active | op_busy;

    power_up_sequencer u_pwr (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .req     (pwr_req),
        .tx_bits (pwr_tx_bits),
        .tx_len  (pwr_tx_len),
        .rx_len  (pwr_rx_len),
        .done    (pwr_done),
        .active  (pwr_active)
    );

    flash_op_sequencer u_op (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .start   (start),
        .addr    (addr),
        .wdata   (wdata),
        .write   (write),
        .erase   (erase),
        .hold    (pwr_active),      // no user commands until power-up is over
        .req     (op_req),
        .tx_bits (op_tx_bits),
        .tx_len  (op_tx_len),
        .rx_len  (op_rx_len),
        .done    (op_done),
        .rx_data (eng_rx_data),
        .rdata   (rdata),
        .valid   (valid),
        .busy    (op_busy)
    );

    frame_arbiter u_arb (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .pwr_req     (pwr_req),
        .pwr_tx_bits (pwr_tx_bits),
        .pwr_tx_len  (pwr_tx_len),
        .pwr_rx_len  (pwr_rx_len),
        .pwr_done    (pwr_done),
        .op_req      (op_req),
        .op_tx_bits  (op_tx_bits),
        .op_tx_len   (op_tx_len),
        .op_rx_len   (op_rx_len),
        .op_done     (op_done),
        .eng_req     (eng_req),
        .eng_tx_bits (eng_tx_bits),
        .eng_tx_len  (eng_tx_len),
        .eng_rx_len  (eng_rx_len),
        .eng_done    (eng_done)
    );

    spi_frame_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_eng (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .req        (eng_req),
        .tx_bits    (eng_tx_bits),
        .tx_len     (eng_tx_len),
        .rx_len     (eng_rx_len),
        .done       (eng_done),
        .rx_data    (eng_rx_data),
        .flash_cs   (flash_cs),
        .flash_sck  (flash_sck),
        .flash_mosi (flash_mosi),
        .flash_miso (flash_miso)
    );

endmodule

// ==== tb/spi_flash_model.sv ====
`timescale 1ns/1ps

module spi_flash_model (
    input  logic       flash_cs,
    input  logic       flash_sck,
    input  logic       flash_mosi,
    output logic       flash_miso,
    output int         n_read_id,
    output int         n_wren,
    output int         n_read,
    output int         n_program,
    output int         n_erase,
    output int         n_status,
    output int         n_no_wren,
    output logic [7:0] first_op,
    output logic [7:0] second_op
);

    localparam logic [7:0]  OP_READ_ID = 8'h90;
    localparam logic [7:0]  OP_WREN    = 8'h06;
    localparam logic [7:0]  OP_READ    = 8'h03;
    localparam logic [7:0]  OP_PROGRAM = 8'h02;
    localparam logic [7:0]  OP_ERASE   = 8'h20;
    localparam logic [7:0]  OP_STATUS  = 8'h05;
    localparam logic [15:0] DEVICE_ID  = 16'hef16;

    logic [31:0] mem [int unsigned];   // sparse map keyed by byte address
    logic [63:0] shift_in;
    logic [31:0] out_word;
    logic [7:0]  opcode;
    logic [7:0]  prev_op;              // opcode of the previous frame
    logic [23:0] cmd_addr;
    logic        out_active;
    logic        wel;                  // write enable latch
    logic        prev_sck;
    logic        prev_cs;
    int          bit_cnt;
    int          busy_reads;           // status reads that still show wip
    int          frames;

    function automatic logic [31:0] word_at(input logic [23:0] a);
        if (mem.exists({8'd0, a})) begin
            return mem[{8'd0, a}];
        end
        return 32'hffff_ffff;
    endfunction

    task automatic sck_rise();
        shift_in = {shift_in[62:0], flash_mosi};
        bit_cnt++;
        if (bit_cnt == 8) begin
            opcode = shift_in[7:0];
            if (opcode == OP_STATUS) begin
                out_word   = {7'd0, busy_reads != 0, 24'd0};
                out_active = 1'b1;
            end
        end
        if (bit_cnt == 32) begin
            cmd_addr = shift_in[23:0];
            if (opcode == OP_READ) begin
                out_word   = word_at(cmd_addr);
                out_active = 1'b1;
            end else if (opcode == OP_READ_ID) begin
                out_word   = {DEVICE_ID, 16'd0};
                out_active = 1'b1;
            end
        end
    endtask

    task automatic end_frame();
        logic [23:0] base;
        int unsigned key;
        if (bit_cnt >= 8) begin
            frames++;
            if (frames == 1) begin
                first_op = opcode;
            end
            if (frames == 2) begin
                second_op = opcode;
            end
            case (opcode)
                OP_READ_ID: n_read_id++;
                OP_READ:    n_read++;
                OP_WREN: begin
                    n_wren++;
                    wel = 1'b1;
                end
                OP_STATUS: begin
                    n_status++;
                    if (busy_reads > 0) begin
                        busy_reads--;
                    end
                end
                OP_PROGRAM: begin
                    n_program++;
                    if (prev_op != OP_WREN) begin
                        n_no_wren++;
                    end
                    if (wel && bit_cnt >= 64) begin
                        // programming can only clear bits
                        mem[{8'd0, cmd_addr}] = word_at(cmd_addr) & shift_in[31:0];
                        wel        = 1'b0;
                        busy_reads = 3;
                    end
                end
                OP_ERASE: begin
                    n_erase++;
                    if (prev_op != OP_WREN) begin
                        n_no_wren++;
                    end
                    if (wel && bit_cnt >= 32) begin
                        base = {cmd_addr[23:12], 12'd0};   // 4 KiB sector
                        for (int i = 0; i < 1024; i++) begin
                            key = {8'd0, base} + 32'(i) * 32'd4;
                            mem.delete(key);
                        end
                        wel        = 1'b0;
                        busy_reads = 3;
                    end
                end
                default: ;
            endcase
            prev_op = opcode;
        end
        flash_miso = 1'b0;
        out_active = 1'b0;
    endtask

    initial begin
        flash_miso = 1'b0;
        n_read_id  = 0;
        n_wren     = 0;
        n_read     = 0;
        n_program  = 0;
        n_erase    = 0;
        n_status   = 0;
        n_no_wren  = 0;
        first_op   = 8'd0;
        second_op  = 8'd0;
        wel        = 1'b0;
        busy_reads = 0;
        frames     = 0;
        bit_cnt    = 0;
        out_active = 1'b0;
        shift_in   = '0;
        out_word   = '0;
        opcode     = '0;
        prev_op    = '0;
        cmd_addr   = '0;
        prev_sck   = 1'b0;
        prev_cs    = 1'b1;
        forever begin
            @(flash_sck or flash_cs);
            if (prev_cs === 1'b1 && flash_cs === 1'b0) begin
                bit_cnt    = 0;   // new frame
                out_active = 1'b0;
            end
            if (flash_cs === 1'b0 && prev_sck === 1'b0 && flash_sck === 1'b1) begin
                sck_rise();
            end
            if (flash_cs === 1'b0 && prev_sck === 1'b1 && flash_sck === 1'b0 && out_active) begin
                flash_miso = out_word[31];   // next bit after falling sck
                out_word   = out_word << 1;
            end
            if (prev_cs === 1'b0 && flash_cs === 1'b1) begin
                end_frame();
            end
            prev_sck = flash_sck;
            prev_cs  = flash_cs;
        end
    end

endmodule

// ==== tb/tb_flash_ctrl.sv ====
`timescale 1ns/1ps

module tb_flash_ctrl;

    localparam int          TIMEOUT      = 4000;   // clocks per wait
    localparam int          NUM_OPS      = 40;
    localparam logic [15:0] SEED         = 16'd62160;
    localparam logic [23:0] SECTOR_BASE  = 24'h03_0000;
    localparam logic [1:0]  KIND_READ    = 2'd0;
    localparam logic [1:0]  KIND_PROGRAM = 2'd1;
    localparam logic [1:0]  KIND_ERASE   = 2'd2;

    logic        i_clk;
    logic        i_reset;
    logic        start;
    logic [23:0] addr;
    logic [31:0] wdata;
    logic        write;
    logic        erase;
    logic [31:0] rdata;
    logic        valid;
    logic        busy;
    logic        flash_cs;
    logic        flash_sck;
    logic        flash_mosi;
    logic        flash_miso;

    int          n_read_id;
    int          n_wren;
    int          n_read;
    int          n_program;
    int          n_erase;
    int          n_status;
    int          n_no_wren;
    logic [7:0]  first_op;
    logic [7:0]  second_op;

    int          exp_read_id;
    int          exp_wren;
    int          exp_read;
    int          exp_program;
    int          exp_erase;
    int          exp_status;
    logic [15:0] lfsr_state;
    logic [31:0] golden_mem [int unsigned];

    flash_ctrl_top #(
        .CLK_DIV (2)
    ) DUT (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .start      (start),
        .addr       (addr),
        .wdata      (wdata),
        .write      (write),
        .erase      (erase),
        .rdata      (rdata),
        .valid      (valid),
        .busy       (busy),
        .flash_cs   (flash_cs),
        .flash_sck  (flash_sck),
        .flash_mosi (flash_mosi),
        .flash_miso (flash_miso)
    );

    spi_flash_model flash (
        .flash_cs   (flash_cs),
        .flash_sck  (flash_sck),
        .flash_mosi (flash_mosi),
        .flash_miso (flash_miso),
        .n_read_id  (n_read_id),
        .n_wren     (n_wren),
        .n_read     (n_read),
        .n_program  (n_program),
        .n_erase    (n_erase),
        .n_status   (n_status),
        .n_no_wren  (n_no_wren),
        .first_op   (first_op),
        .second_op  (second_op)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    task automatic abort_run(input string text);
        $display("%s", text);
        $display("Checks failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        abort_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic pick_addr(input logic sector, input int idx_bits, output logic [23:0] a);
        logic [31:0] idx;
        draw_bits(idx_bits, idx);
        a = SECTOR_BASE + {11'd0, sector, 12'd0} + {12'd0, idx[9:0], 2'b00};
    endtask

    function automatic logic [31:0] golden_word(input logic [23:0] a);
        if (golden_mem.exists({8'd0, a})) begin
            return golden_mem[{8'd0, a}];
        end
        return 32'hffff_ffff;
    endfunction

    task automatic apply_erase(input logic [23:0] a);
        int unsigned key;
        for (int i = 0; i < 1024; i++) begin
            key = {8'd0, a[23:12], 12'd0} + 32'(i) * 32'd4;
            golden_mem.delete(key);
        end
    endtask

    task automatic check_counts();
        assert (n_read_id == exp_read_id) else value_error("n_read_id", n_read_id, exp_read_id);
        assert (n_wren == exp_wren) else value_error("n_wren", n_wren, exp_wren);
        assert (n_read == exp_read) else value_error("n_read", n_read, exp_read);
        assert (n_program == exp_program) else value_error("n_program", n_program, exp_program);
        assert (n_erase == exp_erase) else value_error("n_erase", n_erase, exp_erase);
        assert (n_status == exp_status) else value_error("n_status", n_status, exp_status);
        assert (n_no_wren == 0) else value_error("n_no_wren", n_no_wren, 32'd0);
    endtask

    task automatic wait_power_up();
        int cycles;
        cycles = 0;
        @(posedge i_clk);
        @(negedge i_clk);
        assert (busy === 1'b1) else value_error("busy", {31'd0, busy}, 32'd1);
        while (busy !== 1'b0) begin
            cycles++;
            assert (cycles < TIMEOUT) else abort_run("timeout: busy stayed high after reset");
            @(negedge i_clk);
        end
        assert (first_op === 8'h90) else value_error("first_op", {24'd0, first_op}, 32'h90);
        assert (second_op === 8'h06) else value_error("second_op", {24'd0, second_op}, 32'h06);
        assert (flash_cs === 1'b1) else value_error("flash_cs", {31'd0, flash_cs}, 32'd1);
        assert (flash_sck === 1'b0) else value_error("flash_sck", {31'd0, flash_sck}, 32'd0);
        check_counts();
    endtask

    // one command with an optional stray start while busy
    task automatic run_op(input logic [1:0] kind, input logic [23:0] a, input logic [31:0] d,
                          input logic inject);
        logic [23:0] junk_addr;
        int          cycles;
        logic        seen;
        cycles = 0;
        seen   = 1'b0;
        pick_addr(1'b0, 4, junk_addr);
        @(posedge i_clk);
        start <= 1'b1;
        addr  <= a;
        wdata <= d;
        write <= (kind == KIND_PROGRAM);
        erase <= (kind == KIND_ERASE);
        @(posedge i_clk);
        start <= 1'b0;
        while (!seen) begin
            @(negedge i_clk);
            if (valid === 1'b1) begin
                seen = 1'b1;
            end else begin
                assert (busy === 1'b1) else value_error("busy", {31'd0, busy}, 32'd1);
                cycles++;
                assert (cycles < TIMEOUT) else abort_run("timeout: no valid pulse after start");
                @(posedge i_clk);
                if (inject && cycles == 3) begin
                    start <= 1'b1;   // must be ignored
                    write <= 1'b1;
                    erase <= 1'b0;
                    addr  <= junk_addr;
                    wdata <= 32'd0;
                end else begin
                    start <= 1'b0;
                end
            end
        end
        case (kind)
            KIND_PROGRAM: begin
                golden_mem[{8'd0, a}] = golden_word(a) & d;
                exp_wren++;
                exp_program++;
                exp_status += 4;   // three busy reads and one ready
            end
            KIND_ERASE: begin
                apply_erase(a);
                exp_wren++;
                exp_erase++;
                exp_status += 4;
            end
            default: begin
                exp_read++;
                assert (rdata === golden_word(a))
                else value_error("rdata", rdata, golden_word(a));
            end
        endcase
        @(negedge i_clk);
        assert (valid === 1'b0) else value_error("valid", {31'd0, valid}, 32'd0);
        assert (busy === 1'b0) else value_error("busy", {31'd0, busy}, 32'd0);
        check_counts();
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [23:0] a;
        logic [23:0] a2;
        logic [23:0] erase_addr;
        logic        sector;
        start       <= 1'b0;
        addr        <= '0;
        wdata       <= '0;
        write       <= 1'b0;
        erase       <= 1'b0;
        i_reset     <= 1'b1;
        lfsr_state  = SEED;
        exp_read_id = 1;
        exp_wren    = 1;   // power-up write enable
        exp_read    = 0;
        exp_program = 0;
        exp_erase   = 0;
        exp_status  = 0;
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;
        wait_power_up();
        for (int n = 0; n < NUM_OPS; n++) begin
            draw_bits(2, r);
            draw_bits(1, d);
            sector = d[0];
            case (r[1:0])
                KIND_PROGRAM: begin
                    pick_addr(sector, 4, a);
                    draw_bits(32, d);
                    run_op(KIND_PROGRAM, a, d, 1'b0);
                    run_op(KIND_READ, a, 32'd0, 1'b0);
                end
                KIND_ERASE: begin
                    pick_addr(sector, 4, a);
                    draw_bits(32, d);
                    run_op(KIND_PROGRAM, a, d, 1'b0);   // word the erase has to clear
                    pick_addr(~sector, 4, a2);
                    draw_bits(32, d);
                    run_op(KIND_PROGRAM, a2, d, 1'b0);
                    pick_addr(sector, 10, erase_addr);
                    run_op(KIND_ERASE, erase_addr, 32'd0, 1'b0);
                    run_op(KIND_READ, a, 32'd0, 1'b0);
                    assert (rdata === 32'hffff_ffff)
                    else value_error("rdata", rdata, 32'hffff_ffff);
                    pick_addr(sector, 10, a);
                    run_op(KIND_READ, a, 32'd0, 1'b0);
                    assert (rdata === 32'hffff_ffff)
                    else value_error("rdata", rdata, 32'hffff_ffff);
                    run_op(KIND_READ, a2, 32'd0, 1'b0);   // other sector keeps its data
                end
                default: begin
                    pick_addr(sector, 4, a);
                    run_op(KIND_READ, a, 32'd0, 1'b1);
                end
            endcase
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== project.f ====
hw/flash_ctrl_pkg.sv
hw/power_up_sequencer.sv
hw/flash_op_sequencer.sv
hw/frame_arbiter.sv
hw/spi_frame_engine.sv
hw/flash_ctrl_top.sv
tb/spi_flash_model.sv
tb/tb_flash_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the flash controller testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    -f project.f --top-module tb_flash_ctrl --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
